//--- logic/spi_pkg.sv
//**********************************************************
// Shared widths, register map and divider table of the SPI
// master, referenced by scoped name from RTL and testbench
//**********************************************************

package spi_pkg;

   // Data and register bytes
   typedef logic [7:0] spi_byte_t;
   typedef logic [1:0] spi_cdiv_t;   // SCLK rate select
   typedef logic [2:0] spi_bcnt_t;   // Bits remaining in a transfer

   // Shift engine states
   typedef enum logic [1:0] {
      SPI_IDLE,   // SCLK parked at CPOL
      SPI_LEAD,   // Waiting for leading edge
      SPI_TRAIL   // Waiting for trailing edge
   } spi_state_e;

   // Register addresses on the single address bit
   localparam logic SPI_ADR_CTRL = 1'b0;
   localparam logic SPI_ADR_DATA = 1'b1;

   // Control/status byte layout
   localparam int unsigned SPIC_SPIE = 7;   // Interrupt enable
   localparam int unsigned SPIC_SPEN = 6;   // Peripheral enable
   localparam int unsigned SPIC_SPIF = 5;   // Transfer complete, read only
   localparam int unsigned SPIC_WCOL = 4;   // Write collision, read only
   localparam int unsigned SPIC_CPOL = 3;
   localparam int unsigned SPIC_CPHA = 2;
   // Bits 1:0 carry the divider select

   // SCLK half-period in system clocks per divider select
   // Full periods come out at 2, 4, 16 and 32 clocks
   function automatic int unsigned spi_half_period(input spi_cdiv_t sel);
      case (sel)
         2'd0:    return 1;
         2'd1:    return 2;
         2'd2:    return 8;
         default: return 16;
      endcase
   endfunction

endpackage

//--- logic/spi_ctrl_if.sv
//**********************************************************
// Control, status and data bundle between the register
// block and the shift engine
//**********************************************************

`timescale 1ns/1ns

interface spi_ctrl_if;

   // Set up by the register block
   logic                  cpol;      // SCLK idle level
   logic                  cpha;      // Sample on trailing edge when set
   spi_pkg::spi_cdiv_t    cdiv;      // Rate select, also to clock gen
   spi_pkg::spi_byte_t    tx_byte;   // Byte to shift out
   logic                  start;     // One clock, tx_byte valid

   // Returned by the engine
   logic                  busy;      // Transfer in progress
   logic                  done;      // One clock at end of transfer
   spi_pkg::spi_byte_t    rx_byte;   // Valid with done

   modport regs_mp (
      output cpol, cpha, cdiv, tx_byte, start,
      input  busy, done, rx_byte
   );

   // Engine does not look at cdiv, the clock gen handles rate
   modport engine_mp (
      input  cpol, cpha, tx_byte, start,
      output busy, done, rx_byte
   );

endinterface

//--- logic/spi_wb_regs.sv
//**********************************************************
// Wishbone slave holding control, status and data registers,
// launches transfers and raises the SPI interrupt
//**********************************************************

`timescale 1ns/1ns

module spi_wb_regs #(
   parameter int unsigned PRESCALE_W = 4   // Clock gen counter width
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                wb_adr_i,
   input  spi_pkg::spi_byte_t  wb_dat_i,
   input  logic                wb_sel_i,
   input  logic                wb_we_i,
   input  logic                wb_stb_i,
   output spi_pkg::spi_byte_t  wb_dat_o,
   output logic                wb_ack_o,
   output logic                int_o,
   spi_ctrl_if.regs_mp         ctrl
);

   logic                spie_q, spen_q;     // Writable enables
   logic                spif_q, wcol_q;     // Status flags
   logic                cpol_q, cpha_q;
   spi_pkg::spi_cdiv_t  cdiv_q;
   spi_pkg::spi_byte_t  tx_q;               // Byte handed to engine
   spi_pkg::spi_byte_t  rx_q;               // Last received byte
   logic                start_q;
   spi_pkg::spi_byte_t  status;

   logic access_new;   // First cycle of an access
   logic wr_ctrl, wr_data, rd_data;
   logic eng_busy;

   // Access qualified by sel, suppressed while ack is up
   assign access_new = wb_stb_i & wb_sel_i & ~wb_ack_o;
   assign wr_ctrl    = access_new & wb_we_i & (wb_adr_i == spi_pkg::SPI_ADR_CTRL);
   assign wr_data    = access_new & wb_we_i & (wb_adr_i == spi_pkg::SPI_ADR_DATA);
   assign rd_data    = access_new & ~wb_we_i & (wb_adr_i == spi_pkg::SPI_ADR_DATA);

   // A start still in flight counts as busy
   assign eng_busy = ctrl.busy | start_q;

   // Status byte as the CPU sees it
   always_comb begin
      status                      = '0;
      status[spi_pkg::SPIC_SPIE]  = spie_q;
      status[spi_pkg::SPIC_SPEN]  = spen_q;
      status[spi_pkg::SPIC_SPIF]  = spif_q;
      status[spi_pkg::SPIC_WCOL]  = wcol_q;
      status[spi_pkg::SPIC_CPOL]  = cpol_q;
      status[spi_pkg::SPIC_CPHA]  = cpha_q;
      status[1:0]                 = cdiv_q;
   end

   // Bus side, ack and read data
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
      end else begin
         wb_ack_o <= wb_stb_i & wb_sel_i & ~wb_ack_o;   // Single clock, then drops
         if (access_new)
            wb_dat_o <= (wb_adr_i == spi_pkg::SPI_ADR_DATA) ? rx_q : status;
      end
   end

   // Control register and flags
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         spie_q <= 1'b0;
         spen_q <= 1'b0;
         cpol_q <= 1'b0;
         cpha_q <= 1'b0;
         cdiv_q <= '0;
         spif_q <= 1'b0;
         wcol_q <= 1'b0;
         int_o  <= 1'b0;
      end else begin
         if (wr_ctrl) begin
            spie_q <= wb_dat_i[spi_pkg::SPIC_SPIE];
            spen_q <= wb_dat_i[spi_pkg::SPIC_SPEN];
            cpol_q <= wb_dat_i[spi_pkg::SPIC_CPOL];
            cpha_q <= wb_dat_i[spi_pkg::SPIC_CPHA];
            cdiv_q <= wb_dat_i[1:0];
            wcol_q <= 1'b0;                          // Control write clears WCOL
         end else if (wr_data && spen_q && eng_busy) begin
            wcol_q <= 1'b1;                          // Byte dropped
         end
         if (ctrl.done)
            spif_q <= 1'b1;                          // Set beats a same-cycle read
         else if (rd_data)
            spif_q <= 1'b0;
         int_o <= spif_q & spie_q;
      end
   end

   // Transfer launch and receive capture
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         start_q <= 1'b0;
         tx_q    <= '0;
         rx_q    <= '0;
      end else begin
         start_q <= wr_data & spen_q & ~eng_busy;
         if (wr_data && spen_q && !eng_busy)
            tx_q <= wb_dat_i;
         if (ctrl.done)
            rx_q <= ctrl.rx_byte;
      end
   end

   assign ctrl.cpol    = cpol_q;
   assign ctrl.cpha    = cpha_q;
   assign ctrl.cdiv    = cdiv_q;
   assign ctrl.tx_byte = tx_q;
   assign ctrl.start   = start_q;

endmodule

//--- logic/spi_clk_gen.sv
//**********************************************************
// Loadable down-counter giving one tick per SCLK half-period
//**********************************************************

`timescale 1ns/1ns

module spi_clk_gen #(
   parameter int unsigned PRESCALE_W = 4   // Holds largest half-period minus one
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  spi_pkg::spi_cdiv_t  cdiv_i,
   input  logic                run_i,
   output logic                tick_o
);

   logic [PRESCALE_W-1:0] cnt_q;
   logic [PRESCALE_W-1:0] reload;
   logic                  expired;

   // Count loaded with half-period minus one
   assign reload  = PRESCALE_W'(spi_pkg::spi_half_period(cdiv_i) - 1);
   assign expired = (cnt_q == '0);

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         cnt_q <= '0;
      end else if (!run_i) begin
         cnt_q <= reload;            // Hold preset while engine idle
      end else if (expired) begin
         cnt_q <= reload;            // Start next half-period
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // One clock wide, only while the engine runs
   assign tick_o = run_i & expired;

endmodule

//--- logic/spi_shift_engine.sv
//**********************************************************
// SPI transfer FSM, drives SCLK and MOSI, samples MISO and
// counts the eight bits of a byte
//**********************************************************

`timescale 1ns/1ns

module spi_shift_engine (
   input  logic         wb_clk_i,
   input  logic         wb_rst_i,
   input  logic         tick_i,       // Half-period tick
   input  logic         mspi_dat_i,   // MISO
   output logic         run_o,        // Keeps clock gen counting
   output logic         mspi_clk_o,   // SCLK
   output logic         mspi_dat_o,   // MOSI
   spi_ctrl_if.engine_mp ctrl
);

   spi_pkg::spi_state_e state_q;
   spi_pkg::spi_byte_t  sreg_q;     // Out at top, in at bottom
   spi_pkg::spi_bcnt_t  bcnt_q;     // Bits remaining after this one
   logic                sclk_q;
   logic                mosi_q;
   logic                miso_q;     // Leading edge sample, CPHA 0 only
   logic                done_q;
   logic                new_bit;

   // Bit entering the shift register on a trailing edge
   assign new_bit = ctrl.cpha ? mspi_dat_i : miso_q;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q <= spi_pkg::SPI_IDLE;
         sreg_q  <= '0;
         bcnt_q  <= '0;
         sclk_q  <= 1'b0;
         mosi_q  <= 1'b0;
         miso_q  <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            spi_pkg::SPI_IDLE: begin
               if (ctrl.start) begin
                  sreg_q  <= ctrl.tx_byte;
                  bcnt_q  <= 3'd7;
                  sclk_q  <= ctrl.cpol;
                  mosi_q  <= ctrl.tx_byte[7];   // MSB ready before first edge
                  state_q <= spi_pkg::SPI_LEAD;
               end
            end
            spi_pkg::SPI_LEAD: begin
               if (tick_i) begin
                  sclk_q <= ~sclk_q;
                  if (!ctrl.cpha)
                     miso_q <= mspi_dat_i;        // Sample on leading edge
                  else
                     mosi_q <= sreg_q[7];         // Drive on leading edge
                  state_q <= spi_pkg::SPI_TRAIL;
               end
            end
            spi_pkg::SPI_TRAIL: begin
               if (tick_i) begin
                  sclk_q <= ~sclk_q;               // Lands back on CPOL
                  sreg_q <= {sreg_q[6:0], new_bit};
                  if (!ctrl.cpha)
                     mosi_q <= sreg_q[6];         // Next bit after trailing edge
                  if (bcnt_q == '0) begin
                     done_q  <= 1'b1;             // sreg holds the received byte
                     state_q <= spi_pkg::SPI_IDLE;
                  end else begin
                     bcnt_q  <= bcnt_q - 1'b1;
                     state_q <= spi_pkg::SPI_LEAD;
                  end
               end
            end
            default: state_q <= spi_pkg::SPI_IDLE;
         endcase
      end
   end

   assign run_o         = (state_q != spi_pkg::SPI_IDLE);
   assign ctrl.busy     = run_o;
   assign ctrl.done     = done_q;
   assign ctrl.rx_byte  = sreg_q;

   // SCLK follows CPOL directly while idle
   assign mspi_clk_o = run_o ? sclk_q : ctrl.cpol;
   assign mspi_dat_o = mosi_q;

endmodule

//--- logic/vpio_mspi_top.sv
//**********************************************************
// Wishbone SPI master top, plain bus and SPI pins
//**********************************************************

`timescale 1ns/1ns

module vpio_mspi_top #(
   parameter int unsigned PRESCALE_W = 4   // Clock gen counter width
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   // Wishbone slave
   input  logic                wb_adr_i,
   input  spi_pkg::spi_byte_t  wb_dat_i,
   input  logic                wb_sel_i,
   input  logic                wb_we_i,
   input  logic                wb_stb_i,
   output spi_pkg::spi_byte_t  wb_dat_o,
   output logic                wb_ack_o,
   output logic                int_o,
   // SPI pins
   output logic                mspi_clk_o,   // SCLK
   output logic                mspi_dat_o,   // MOSI
   input  logic                mspi_dat_i    // MISO
);

   logic tick;   // Half-period tick
   logic run;    // Engine active

   spi_ctrl_if ctrl_if ();

   spi_wb_regs #(
      .PRESCALE_W (PRESCALE_W)
   ) regs_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .int_o    (int_o),
      .ctrl     (ctrl_if.regs_mp)
   );

   spi_clk_gen #(
      .PRESCALE_W (PRESCALE_W)
   ) clk_gen_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cdiv_i   (ctrl_if.cdiv),
      .run_i    (run),
      .tick_o   (tick)
   );

   spi_shift_engine engine_inst (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .tick_i     (tick),
      .mspi_dat_i (mspi_dat_i),
      .run_o      (run),
      .mspi_clk_o (mspi_clk_o),
      .mspi_dat_o (mspi_dat_o),
      .ctrl       (ctrl_if.engine_mp)
   );

endmodule

//--- verification/mspi_tb_properties.sv
//**********************************************************
// Bus and SPI protocol assertions, bound into the SPI top
//**********************************************************

`timescale 1ns/1ns

module mspi_tb_properties (
   input logic clk_i,
   input logic rst_i,
   input logic stb_i,    // wb_stb_i
   input logic sel_i,    // wb_sel_i
   input logic ack_i,    // wb_ack_o
   input logic sclk_i,   // Engine SCLK register
   input logic cpol_i,   // Programmed idle level
   input logic busy_i,   // Engine running
   input logic done_i,   // End of transfer pulse
   input logic spif_i    // Transfer complete flag
);

   // New access answered by a single clock ack
   ack_single_a: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(stb_i && sel_i) |=> ack_i ##1 !ack_i)
      else begin
         $error("wb_ack_o missing after an access or high for two clocks");
         mspi_tb.err_cnt++;
      end

   // Engine SCLK back on CPOL when a transfer ends
   sclk_idle_a: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(busy_i) |-> (sclk_i == cpol_i))
      else begin
         $error("SCLK not back at CPOL when the engine went idle");
         mspi_tb.err_cnt++;
      end

   done_spif_a: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |=> spif_i)
      else begin
         $error("SPIF not set after done");
         mspi_tb.err_cnt++;
      end

endmodule

//--- verification/mspi_tb.sv
//**********************************************************
// Directed testbench for the Wishbone SPI master, with an
// SPI slave model following CPOL/CPHA and a watchdog
//**********************************************************

`timescale 1ns/1ns

module mspi_tb;

   // Full SCLK period in clocks per divider select
   localparam int unsigned SCLK_PERIOD [4] = '{2, 4, 16, 32};
   // Worst-case transfers: seven at div 0, one at div 1, two at div 2, one at div 3
   localparam int unsigned XFER_CYC = 7 * 18 + 34 + 2 * 130 + 258;
   localparam int unsigned WATCHDOG_CYC = XFER_CYC + 2000;   // Register traffic margin

   logic               wb_clk, wb_rst;
   logic               wb_adr, wb_sel, wb_we, wb_stb;
   spi_pkg::spi_byte_t wb_dat_w, wb_dat_r;
   logic               wb_ack, irq;
   logic               sclk, mosi, miso;

   int err_cnt, checks, tests_run, tests_failed, test_err0;

   // Slave model state
   logic               slv_armed, slv_cpol, slv_cpha, sclk_prev;
   spi_pkg::spi_byte_t slv_sh, slv_rx;   // Outgoing and received bytes
   int                 slv_bits, sclk_rises;

   // Clock counts at busy rise and SPIF rise
   int   cyc, busy_t, spif_t;
   logic busy_prev, spif_prev;

   initial wb_clk = 1'b0;
   always #2 wb_clk = ~wb_clk;   // 4 ns period

   vpio_mspi_top #(.PRESCALE_W(4)) vpio_mspi_inst (
      .wb_clk_i   (wb_clk),
      .wb_rst_i   (wb_rst),
      .wb_adr_i   (wb_adr),
      .wb_dat_i   (wb_dat_w),
      .wb_sel_i   (wb_sel),
      .wb_we_i    (wb_we),
      .wb_stb_i   (wb_stb),
      .wb_dat_o   (wb_dat_r),
      .wb_ack_o   (wb_ack),
      .int_o      (irq),
      .mspi_clk_o (sclk),
      .mspi_dat_o (mosi),
      .mspi_dat_i (miso)
   );

   bind vpio_mspi_top mspi_tb_properties props_inst (
      .clk_i  (wb_clk_i),
      .rst_i  (wb_rst_i),
      .stb_i  (wb_stb_i),
      .sel_i  (wb_sel_i),
      .ack_i  (wb_ack_o),
      .sclk_i (engine_inst.sclk_q),
      .cpol_i (ctrl_if.cpol),
      .busy_i (ctrl_if.busy),
      .done_i (ctrl_if.done),
      .spif_i (regs_inst.spif_q)
   );

   // Timestamps for the rate test, taken mid-cycle
   always @(negedge wb_clk) begin
      if (vpio_mspi_inst.ctrl_if.busy && !busy_prev)
         busy_t = cyc;
      if (vpio_mspi_inst.regs_inst.spif_q && !spif_prev)
         spif_t = cyc;
      busy_prev = vpio_mspi_inst.ctrl_if.busy;
      spif_prev = vpio_mspi_inst.regs_inst.spif_q;
      cyc       = cyc + 1;
   end

   // SPI slave, sees SCLK edges half a clock late
   always @(negedge wb_clk) begin
      if (slv_armed && sclk != sclk_prev) begin
         if (sclk)
            sclk_rises = sclk_rises + 1;
         if ((sclk_prev == slv_cpol) != slv_cpha) begin
            slv_rx   = {slv_rx[6:0], mosi};   // Sampling edge
            slv_bits = slv_bits + 1;
         end else if (sclk_prev == slv_cpol) begin
            miso   = slv_sh[7];               // CPHA 1 leading edge drives
            slv_sh = slv_sh << 1;
         end else begin
            slv_sh = slv_sh << 1;             // CPHA 0 trailing edge drives
            miso   = slv_sh[7];
         end
      end
      sclk_prev = sclk;
   end

   task automatic check_eq(input string name, input int unsigned exp, input int unsigned act);
      checks++;
      assert (exp == act)
         else begin
            $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            err_cnt++;
         end
   endtask

   // One bus cycle, returns at the falling edge after an idle clock
   task automatic wb_access(input logic we, input logic adr, input spi_pkg::spi_byte_t wdat,
                            output spi_pkg::spi_byte_t rdat);
      int n;
      n        = 0;
      wb_stb   = 1'b1;
      wb_sel   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      do begin
         @(negedge wb_clk);
         n++;
      end while (!wb_ack && n < 8);
      checks++;
      assert (wb_ack)
         else begin
            $display("Bus access to address %0d was never acknowledged", adr);
            err_cnt++;
         end
      rdat   = wb_dat_r;
      wb_stb = 1'b0;
      wb_sel = 1'b0;
      wb_we  = 1'b0;
      @(negedge wb_clk);
   endtask

   task automatic wb_write(input logic adr, input spi_pkg::spi_byte_t dat);
      spi_pkg::spi_byte_t unused;
      wb_access(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic adr, output spi_pkg::spi_byte_t dat);
      wb_access(1'b0, adr, '0, dat);
   endtask

   function automatic spi_pkg::spi_byte_t ctrl_byte(input logic spie, input logic spen,
                                                    input logic cpol, input logic cpha,
                                                    input logic [1:0] div);
      spi_pkg::spi_byte_t b;
      b                     = '0;
      b[spi_pkg::SPIC_SPIE] = spie;
      b[spi_pkg::SPIC_SPEN] = spen;
      b[spi_pkg::SPIC_CPOL] = cpol;
      b[spi_pkg::SPIC_CPHA] = cpha;
      b[1:0]                = div;
      return b;
   endfunction

   task automatic arm_slave(input logic cpol, input logic cpha, input spi_pkg::spi_byte_t tx);
      slv_cpol   = cpol;
      slv_cpha   = cpha;
      slv_sh     = tx;
      slv_rx     = '0;
      slv_bits   = 0;
      sclk_rises = 0;
      miso       = cpha ? 1'b0 : tx[7];   // CPHA 0 needs MSB before first edge
      slv_armed  = 1'b1;
   endtask

   // Program control, arm the slave, write the data byte
   task automatic start_xfer(input spi_pkg::spi_byte_t ctrl, input spi_pkg::spi_byte_t mtx,
                             input spi_pkg::spi_byte_t stx);
      wb_write(spi_pkg::SPI_ADR_CTRL, ctrl);
      arm_slave(ctrl[spi_pkg::SPIC_CPOL], ctrl[spi_pkg::SPIC_CPHA], stx);
      wb_write(spi_pkg::SPI_ADR_DATA, mtx);
   endtask

   // Poll status until SPIF, bounded
   task automatic wait_spif(input string name);
      spi_pkg::spi_byte_t st;
      int polls;
      st    = '0;
      polls = 0;
      while (!st[spi_pkg::SPIC_SPIF] && polls < 200) begin
         wb_read(spi_pkg::SPI_ADR_CTRL, st);
         polls++;
      end
      checks++;
      assert (st[spi_pkg::SPIC_SPIF])
         else begin
            $display("%s: transfer never completed, SPIF stayed low", name);
            err_cnt++;
         end
      slv_armed = 1'b0;
   endtask

   // Both directions of the byte, SPIF cleared by the data read
   task automatic check_xfer(input string name, input spi_pkg::spi_byte_t mtx,
                             input spi_pkg::spi_byte_t stx);
      spi_pkg::spi_byte_t rd;
      check_eq({name, " slave rx"}, mtx, slv_rx);
      check_eq({name, " bit count"}, 8, slv_bits);
      wb_read(spi_pkg::SPI_ADR_DATA, rd);
      check_eq({name, " master rx"}, stx, rd);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt == test_err0) begin
         $display("%s: PASS", name);
      end else begin
         $display("%s: FAIL, %0d error(s)", name, err_cnt - test_err0);
         tests_failed++;
      end
      test_err0 = err_cnt;
   endtask

   task automatic test_reset_regs();
      spi_pkg::spi_byte_t rd, wd;
      wb_read(spi_pkg::SPI_ADR_CTRL, rd);
      check_eq("reset_regs ctrl", 0, rd);
      wb_read(spi_pkg::SPI_ADR_DATA, rd);
      check_eq("reset_regs data", 0, rd);
      check_eq("reset_regs int_o", 0, irq);
      for (int i = 0; i < 4; i++) begin
         wd = (i == 0) ? 8'hFF : spi_pkg::spi_byte_t'($urandom);
         wb_write(spi_pkg::SPI_ADR_CTRL, wd);
         wb_read(spi_pkg::SPI_ADR_CTRL, rd);
         check_eq("reset_regs readback", wd & 8'hCF, rd);   // SPIF, WCOL read only
      end
      wb_write(spi_pkg::SPI_ADR_CTRL, 8'h00);
      end_test("reset_regs");
   endtask

   task automatic test_modes();
      spi_pkg::spi_byte_t mtx, stx;
      for (int m = 0; m < 4; m++) begin
         mtx = $urandom;
         stx = $urandom;
         start_xfer(ctrl_byte(1'b0, 1'b1, m[1], m[0], 2'd0), mtx, stx);
         wait_spif("transfer_modes");
         check_xfer($sformatf("transfer_modes mode %0d", m), mtx, stx);
      end
      end_test("transfer_modes");
   endtask

   task automatic test_dividers();
      spi_pkg::spi_byte_t mtx, stx;
      int unsigned exp_cyc;
      for (int d = 0; d < 4; d++) begin
         mtx     = $urandom;
         stx     = $urandom;
         exp_cyc = 8 * SCLK_PERIOD[d];   // 16 half-periods
         start_xfer(ctrl_byte(1'b0, 1'b1, 1'b0, 1'b0, d[1:0]), mtx, stx);
         wait_spif("dividers");
         check_eq($sformatf("dividers div %0d edges", d), 8, sclk_rises);
         checks++;
         assert (spif_t - busy_t >= exp_cyc && spif_t - busy_t <= exp_cyc + 2)
            else begin
               $display("Error dividers div %0d: expected %0d..%0d clocks, actual %0d",
                        d, exp_cyc, exp_cyc + 2, spif_t - busy_t);
               err_cnt++;
            end
         check_xfer($sformatf("dividers div %0d", d), mtx, stx);
      end
      end_test("dividers");
   endtask

   task automatic test_flags_irq();
      spi_pkg::spi_byte_t mtx, stx, rd;
      int n;
      mtx = $urandom;
      stx = $urandom;
      start_xfer(ctrl_byte(1'b1, 1'b1, 1'b0, 1'b0, 2'd0), mtx, stx);
      n = 0;
      while (!irq && n < 100) begin
         @(negedge wb_clk);
         n++;
      end
      check_eq("flags_irq int_o set", 1, irq);
      slv_armed = 1'b0;
      wb_read(spi_pkg::SPI_ADR_CTRL, rd);
      check_eq("flags_irq spif set", 1, rd[spi_pkg::SPIC_SPIF]);
      check_xfer("flags_irq", mtx, stx);
      wb_read(spi_pkg::SPI_ADR_CTRL, rd);
      check_eq("flags_irq spif cleared", 0, rd[spi_pkg::SPIC_SPIF]);
      check_eq("flags_irq int_o cleared", 0, irq);
      // Same transfer with SPIE off
      start_xfer(ctrl_byte(1'b0, 1'b1, 1'b0, 1'b0, 2'd0), mtx, stx);
      wait_spif("flags_irq");
      repeat (2) @(negedge wb_clk);
      check_eq("flags_irq int_o masked", 0, irq);
      check_xfer("flags_irq masked", mtx, stx);
      end_test("flags_irq");
   endtask

   task automatic test_collision();
      spi_pkg::spi_byte_t mtx, stx, rd;
      mtx = $urandom;
      stx = $urandom;
      start_xfer(ctrl_byte(1'b0, 1'b1, 1'b0, 1'b0, 2'd2), mtx, stx);
      wb_write(spi_pkg::SPI_ADR_DATA, ~mtx);   // Lands mid-transfer
      wb_read(spi_pkg::SPI_ADR_CTRL, rd);
      check_eq("collision wcol set", 1, rd[spi_pkg::SPIC_WCOL]);
      wait_spif("collision");
      check_xfer("collision", mtx, stx);
      wb_write(spi_pkg::SPI_ADR_CTRL, ctrl_byte(1'b0, 1'b1, 1'b0, 1'b0, 2'd2));
      wb_read(spi_pkg::SPI_ADR_CTRL, rd);
      check_eq("collision wcol cleared", 0, rd[spi_pkg::SPIC_WCOL]);
      end_test("collision");
   endtask

   task automatic test_disabled();
      spi_pkg::spi_byte_t rd;
      start_xfer(ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 2'd0), $urandom, $urandom);
      repeat (2 * (8 * SCLK_PERIOD[0] + 2)) @(negedge wb_clk);   // Twice a div 0 transfer
      slv_armed = 1'b0;
      check_eq("disabled sclk edges", 0, sclk_rises);
      wb_read(spi_pkg::SPI_ADR_CTRL, rd);
      check_eq("disabled spif", 0, rd[spi_pkg::SPIC_SPIF]);
      end_test("disabled");
   endtask

   initial begin
      void'($urandom(67474));
      err_cnt      = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_err0    = 0;
      cyc          = 0;
      busy_t       = 0;
      spif_t       = 0;
      busy_prev    = 1'b0;
      spif_prev    = 1'b0;
      slv_armed    = 1'b0;
      sclk_prev    = 1'b0;
      wb_rst       = 1'b1;
      wb_adr       = 1'b0;
      wb_sel       = 1'b0;
      wb_we        = 1'b0;
      wb_stb       = 1'b0;
      wb_dat_w     = '0;
      miso         = 1'b0;
      repeat (4) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;
      @(negedge wb_clk);
      test_reset_regs();
      test_modes();
      test_dividers();
      test_flags_irq();
      test_collision();
      test_disabled();
      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, err_cnt);
      if (err_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Run bound by the total transfer time plus margin
   initial begin
      repeat (WATCHDOG_CYC) @(posedge wb_clk);
      $display("Watchdog: run exceeded %0d clocks and was stopped", WATCHDOG_CYC);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- vpio_mspi.f
logic/spi_pkg.sv
logic/spi_ctrl_if.sv
logic/spi_wb_regs.sv
logic/spi_clk_gen.sv
logic/spi_shift_engine.sv
logic/vpio_mspi_top.sv
verification/mspi_tb_properties.sv
verification/mspi_tb.sv
